//--- rtl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and address width
`define CPU_XLEN 32

// Register file address width, 32 entries
`define CPU_REG_AW 5

`define CPU_RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define CPU_NOP 32'h0000_0013

`endif

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,  // ADD, SUB, AND, OR
    OP_IMM    = 7'b0010011,  // ADDI
    OP_LOAD   = 7'b0000011,  // LW
    OP_STORE  = 7'b0100011,  // SW
    OP_BRANCH = 7'b1100011   // BEQ
  } opcode_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_AND = 2'd2,
    ALU_OR  = 2'd3
  } alu_op_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Function fields
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_ADDI    = 3'b000;
  localparam logic [2:0] F3_WORD    = 3'b010;  // Shared by LW and SW
  localparam logic [2:0] F3_BEQ     = 3'b000;

  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

endpackage

//--- rtl/pipe_pkg.sv
`include "cpu_cfg.svh"

package pipe_pkg;

  // Source of an execute operand
  typedef enum logic [1:0] {
    FWD_NONE      = 2'd0,
    FWD_MEMORY    = 2'd1,
    FWD_WRITEBACK = 2'd2
  } fwd_sel_t;

  typedef struct packed {
    logic [`CPU_XLEN-1:0] instr;
    logic [`CPU_XLEN-1:0] pc;
  } if_id_t;

  typedef struct packed {
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   branch;
    logic                   alu_src_imm;
    rv_isa_pkg::alu_op_t    alu_op;
    logic [`CPU_XLEN-1:0]   rd1;
    logic [`CPU_XLEN-1:0]   rd2;
    logic [`CPU_XLEN-1:0]   imm;
    logic [`CPU_XLEN-1:0]   pc;
    logic [`CPU_REG_AW-1:0] rs1;
    logic [`CPU_REG_AW-1:0] rs2;
    logic [`CPU_REG_AW-1:0] rd;
  } id_ex_t;

  typedef struct packed {
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic [`CPU_XLEN-1:0]   alu_result;  // Also the data address
    logic [`CPU_XLEN-1:0]   store_data;
    logic [`CPU_REG_AW-1:0] rd;
  } ex_mem_t;

  typedef struct packed {
    logic                   reg_write;
    logic [`CPU_XLEN-1:0]   result;
    logic [`CPU_REG_AW-1:0] rd;
  } mem_wb_t;

endpackage

//--- rtl/pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
  parameter type      payload_t = logic,
  parameter payload_t BUBBLE    = '0
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     stall,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // Flush wins over stall so a held stage can still be emptied
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      q <= BUBBLE;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  pipe_pkg::if_id_t       if_id,
  input  pipe_pkg::mem_wb_t      wb,
  output logic [`CPU_REG_AW-1:0] rs1,
  output logic [`CPU_REG_AW-1:0] rs2,
  output pipe_pkg::id_ex_t       id_ex
);
  import rv_isa_pkg::*;

  logic [`CPU_XLEN-1:0]   regs [2**`CPU_REG_AW];
  logic [`CPU_XLEN-1:0]   instr;
  opcode_t                opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [`CPU_REG_AW-1:0] rd;
  logic [`CPU_XLEN-1:0]   imm_i;
  logic [`CPU_XLEN-1:0]   imm_s;
  logic [`CPU_XLEN-1:0]   imm_b;
  logic [`CPU_XLEN-1:0]   rd1_val;
  logic [`CPU_XLEN-1:0]   rd2_val;

  assign instr  = if_id.instr;
  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register file

  always_ff @(posedge clk) begin
    if (rst_n && wb.reg_write && wb.rd != '0) begin
      regs[wb.rd] <= wb.result;
    end
  end

  // A write in this cycle is visible to the read in the same cycle
  assign rd1_val = (rs1 == '0) ? '0 :
                   (wb.reg_write && wb.rd == rs1) ? wb.result : regs[rs1];
  assign rd2_val = (rs2 == '0) ? '0 :
                   (wb.reg_write && wb.rd == rs2) ? wb.result : regs[rs2];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control decode

  always_comb begin
    id_ex        = '0;
    id_ex.alu_op = ALU_ADD;
    id_ex.rd1    = rd1_val;
    id_ex.rd2    = rd2_val;
    id_ex.imm    = imm_i;
    id_ex.pc     = if_id.pc;
    id_ex.rs1    = rs1;
    id_ex.rs2    = rs2;
    id_ex.rd     = rd;
    case (opcode)
      OP_R: begin
        id_ex.reg_write = (funct7 == F7_BASE) || (funct7 == F7_SUB);
        case (funct3)
          F3_ADD_SUB: id_ex.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          F3_AND:     id_ex.alu_op = ALU_AND;
          F3_OR:      id_ex.alu_op = ALU_OR;
          default:    id_ex.reg_write = 1'b0;  // Unsupported R-type acts as a NOP
        endcase
      end
      OP_IMM: begin
        id_ex.reg_write   = (funct3 == F3_ADDI);
        id_ex.alu_src_imm = 1'b1;
      end
      OP_LOAD: begin
        id_ex.reg_write   = (funct3 == F3_WORD);
        id_ex.mem_read    = (funct3 == F3_WORD);
        id_ex.alu_src_imm = 1'b1;
      end
      OP_STORE: begin
        id_ex.mem_write   = (funct3 == F3_WORD);
        id_ex.alu_src_imm = 1'b1;
        id_ex.imm         = imm_s;
      end
      OP_BRANCH: begin
        id_ex.branch = (funct3 == F3_BEQ);
        id_ex.imm    = imm_b;
      end
      default: ;
    endcase
  end

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module hazard_unit (
  input  logic [`CPU_REG_AW-1:0] rs1_d,
  input  logic [`CPU_REG_AW-1:0] rs2_d,
  input  logic [`CPU_REG_AW-1:0] rs1_e,
  input  logic [`CPU_REG_AW-1:0] rs2_e,
  input  logic [`CPU_REG_AW-1:0] rd_e,
  input  logic                   mem_read_e,
  input  logic [`CPU_REG_AW-1:0] rd_m,
  input  logic                   reg_write_m,
  input  logic [`CPU_REG_AW-1:0] rd_w,
  input  logic                   reg_write_w,
  input  logic                   branch_taken,
  output logic                   stall_f,
  output logic                   stall_d,
  output logic                   flush_d,
  output logic                   flush_e,
  output pipe_pkg::fwd_sel_t     fwd_a,
  output pipe_pkg::fwd_sel_t     fwd_b
);
  import pipe_pkg::*;

  logic load_use;

  // The younger producer in memory has priority over writeback
  function automatic fwd_sel_t pick_source(input logic [`CPU_REG_AW-1:0] rs);
    if (rs == '0) return FWD_NONE;
    if (reg_write_m && rs == rd_m) return FWD_MEMORY;
    if (reg_write_w && rs == rd_w) return FWD_WRITEBACK;
    return FWD_NONE;
  endfunction

  always_comb begin
    fwd_a = pick_source(rs1_e);
    fwd_b = pick_source(rs2_e);
  end

  assign load_use = mem_read_e && (rd_e != '0) && (rs1_d == rd_e || rs2_d == rd_e);

  assign stall_f = load_use;
  assign stall_d = load_use;
  assign flush_d = branch_taken;            // Drops the instruction being fetched
  assign flush_e = load_use || branch_taken;

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module execute_stage (
  input  pipe_pkg::id_ex_t     id_ex,
  input  pipe_pkg::fwd_sel_t   fwd_a,
  input  pipe_pkg::fwd_sel_t   fwd_b,
  input  logic [`CPU_XLEN-1:0] alu_result_m,
  input  logic [`CPU_XLEN-1:0] result_w,
  output pipe_pkg::ex_mem_t    ex_mem,
  output logic                 branch_taken,
  output logic [`CPU_XLEN-1:0] branch_target
);
  import pipe_pkg::*;
  import rv_isa_pkg::*;

  logic [`CPU_XLEN-1:0] op_a;
  logic [`CPU_XLEN-1:0] rs2_val;
  logic [`CPU_XLEN-1:0] op_b;
  logic [`CPU_XLEN-1:0] alu_y;

  function automatic logic [`CPU_XLEN-1:0] fwd_mux(input fwd_sel_t sel,
                                                   input logic [`CPU_XLEN-1:0] reg_val);
    case (sel)
      FWD_MEMORY:    return alu_result_m;
      FWD_WRITEBACK: return result_w;
      default:       return reg_val;
    endcase
  endfunction

  always_comb begin
    op_a    = fwd_mux(fwd_a, id_ex.rd1);
    rs2_val = fwd_mux(fwd_b, id_ex.rd2);
    op_b    = id_ex.alu_src_imm ? id_ex.imm : rs2_val;
  end

  always_comb begin
    case (id_ex.alu_op)
      ALU_SUB: alu_y = op_a - op_b;
      ALU_AND: alu_y = op_a & op_b;
      ALU_OR:  alu_y = op_a | op_b;
      default: alu_y = op_a + op_b;
    endcase
  end

  // BEQ compares the forwarded register operands directly
  assign branch_taken  = id_ex.branch && (op_a == rs2_val);
  assign branch_target = id_ex.pc + id_ex.imm;

  always_comb begin
    ex_mem.reg_write  = id_ex.reg_write;
    ex_mem.mem_read   = id_ex.mem_read;
    ex_mem.mem_write  = id_ex.mem_write;
    ex_mem.alu_result = alu_y;
    ex_mem.store_data = rs2_val;  // Forwarded so a store sees the latest value
    ex_mem.rd         = id_ex.rd;
  end

endmodule

//--- rtl/pipelined_cpu.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module pipelined_cpu (
  input  logic                 clk,
  input  logic                 rst_n,
  output logic [`CPU_XLEN-1:0] instr_addr,
  input  logic [`CPU_XLEN-1:0] instr_data,
  output logic [`CPU_XLEN-1:0] data_addr,
  output logic [`CPU_XLEN-1:0] data_wdata,
  output logic                 data_we,
  input  logic [`CPU_XLEN-1:0] data_rdata
);
  import pipe_pkg::*;

  localparam if_id_t  IF_ID_BUBBLE  = '{instr: `CPU_NOP, pc: `CPU_RESET_PC};
  localparam id_ex_t  ID_EX_BUBBLE  = '0;
  localparam ex_mem_t EX_MEM_BUBBLE = '0;
  localparam mem_wb_t MEM_WB_BUBBLE = '0;

  logic [`CPU_XLEN-1:0]   pc;
  logic [`CPU_XLEN-1:0]   pc_next;
  if_id_t                 if_id_f;
  if_id_t                 if_id_q;
  id_ex_t                 id_ex_d;
  id_ex_t                 id_ex_q;
  ex_mem_t                ex_mem_e;
  ex_mem_t                ex_mem_q;
  mem_wb_t                mem_wb_m;
  mem_wb_t                mem_wb_q;
  logic [`CPU_REG_AW-1:0] rs1_d;
  logic [`CPU_REG_AW-1:0] rs2_d;
  logic                   stall_f;
  logic                   stall_d;
  logic                   flush_d;
  logic                   flush_e;
  fwd_sel_t               fwd_a;
  fwd_sel_t               fwd_b;
  logic                   branch_taken;
  logic [`CPU_XLEN-1:0]   branch_target;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch

  assign pc_next = branch_taken ? branch_target : pc + `CPU_XLEN'd4;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `CPU_RESET_PC;
    end else if (!stall_f) begin
      pc <= pc_next;
    end
  end

  assign instr_addr = pc;
  assign if_id_f    = '{instr: instr_data, pc: pc};

  pipe_reg #(.payload_t(if_id_t), .BUBBLE(IF_ID_BUBBLE)) if_id_reg (
    .clk(clk), .rst_n(rst_n), .stall(stall_d), .flush(flush_d), .d(if_id_f), .q(if_id_q)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode and hazards

  decode_stage decode (
    .clk(clk), .rst_n(rst_n), .if_id(if_id_q), .wb(mem_wb_q),
    .rs1(rs1_d), .rs2(rs2_d), .id_ex(id_ex_d)
  );

  hazard_unit hazards (
    .rs1_d(rs1_d), .rs2_d(rs2_d), .rs1_e(id_ex_q.rs1), .rs2_e(id_ex_q.rs2),
    .rd_e(id_ex_q.rd), .mem_read_e(id_ex_q.mem_read),
    .rd_m(ex_mem_q.rd), .reg_write_m(ex_mem_q.reg_write),
    .rd_w(mem_wb_q.rd), .reg_write_w(mem_wb_q.reg_write), .branch_taken(branch_taken),
    .stall_f(stall_f), .stall_d(stall_d), .flush_d(flush_d), .flush_e(flush_e),
    .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  pipe_reg #(.payload_t(id_ex_t), .BUBBLE(ID_EX_BUBBLE)) id_ex_reg (
    .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(flush_e), .d(id_ex_d), .q(id_ex_q)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Execute

  execute_stage execute (
    .id_ex(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .alu_result_m(ex_mem_q.alu_result), .result_w(mem_wb_q.result),
    .ex_mem(ex_mem_e), .branch_taken(branch_taken), .branch_target(branch_target)
  );

  pipe_reg #(.payload_t(ex_mem_t), .BUBBLE(EX_MEM_BUBBLE)) ex_mem_reg (
    .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0), .d(ex_mem_e), .q(ex_mem_q)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory and writeback

  assign data_addr  = ex_mem_q.alu_result;
  assign data_wdata = ex_mem_q.store_data;
  assign data_we    = ex_mem_q.mem_write;

  always_comb begin
    mem_wb_m.reg_write = ex_mem_q.reg_write;
    mem_wb_m.result    = ex_mem_q.mem_read ? data_rdata : ex_mem_q.alu_result;
    mem_wb_m.rd        = ex_mem_q.rd;
  end

  // Its output is the writeback triple for the register file and forwarding
  pipe_reg #(.payload_t(mem_wb_t), .BUBBLE(MEM_WB_BUBBLE)) mem_wb_reg (
    .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0), .d(mem_wb_m), .q(mem_wb_q)
  );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;  // Released off the edge like every other input
  end

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module tb_checker #(
  parameter logic [`CPU_XLEN-1:0] WORD_A = 32'd5,
  parameter logic [`CPU_XLEN-1:0] WORD_B = 32'd9
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 data_we,
  input  logic [`CPU_XLEN-1:0] data_addr,
  input  logic [`CPU_XLEN-1:0] data_wdata,
  input  logic                 final_check,
  output logic                 done,
  output int                   errors
);

  localparam int N_STORES = 10;

  int          seen     = 0;
  logic        reported = 1'b0;
  logic [63:0] expected;

  // Address and value of each store in program order
  function automatic logic [63:0] expected_store(input int n);
    case (n)
      0:       return {32'd8,  WORD_A + WORD_B};
      1:       return {32'd12, WORD_B - WORD_A};
      2:       return {32'd16, WORD_A & WORD_B};
      3:       return {32'd20, WORD_A | WORD_B};
      4:       return {32'd24, WORD_A + 32'd100};
      5:       return {32'd28, 32'd3 + 32'd3 + 32'd3};  // Chain through x8 and x9
      6:       return {32'd32, WORD_B + 32'd7};          // Load then dependent ADDI
      7:       return {32'd44, WORD_A + WORD_B};         // Branch target, x3 again
      8:       return {32'd48, WORD_B - WORD_A};         // Fall through after BEQ
      default: return {32'd52, 32'd0};                   // x0 after a write to it
    endcase
  endfunction

  assign expected = expected_store(seen);
  assign done     = (seen == N_STORES);

  initial errors = 0;

  always @(posedge clk) begin
    if (rst_n && data_we) begin
      if (seen >= N_STORES) begin
        $display("Unexpected extra store of 0x%08h to address 0x%08h at time %0t",
                 data_wdata, data_addr, $time);
        errors <= errors + 1;
      end else begin
        if ({data_addr, data_wdata} !== expected) begin
          $display("Mismatch at time %0t: store %0d wrote 0x%h to 0x%h, expected 0x%h to 0x%h",
                   $time, seen, data_wdata, data_addr, expected[31:0], expected[63:32]);
          errors <= errors + 1;
        end
        seen <= seen + 1;
      end
    end
    if (final_check && !reported) begin
      reported <= 1'b1;
      if (seen < N_STORES) begin
        $display("Missing stores: only %0d of %0d expected stores were seen", seen, N_STORES);
        errors <= errors + 1;
      end
    end
  end

endmodule

//--- testbench/cpu_assertions.sv
`timescale 1ns/100ps

module cpu_assertions (
  input logic clk,
  input logic rst_n,
  input logic data_we,
  input logic stall_f,
  input logic stall_d,
  input logic flush_d,
  input logic flush_e,
  input logic branch_taken
);

  // One reset edge has cleared the memory stage
  reset_no_store: assert property (@(posedge clk) (!rst_n && $past(!rst_n)) |-> !data_we)
    else $error("Store strobe high while the core is held in reset");

  stall_together: assert property (@(posedge clk) disable iff (!rst_n) stall_f |-> stall_d)
    else $error("Fetch stalled without decode stalling");

  stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) stall_d |=> !stall_d)
    else $error("Load-use stall lasted longer than one cycle");

  branch_flush: assert property (@(posedge clk) disable iff (!rst_n)
                                 branch_taken |-> (flush_d && flush_e))
    else $error("Taken branch did not flush decode and execute");

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module tb_top;

  localparam int                   PROG_LEN       = 27;
  localparam int                   TIMEOUT_CYCLES = 4 * PROG_LEN + 40;
  localparam int                   N_ROWS         = 3;
  localparam logic [`CPU_XLEN-1:0] WORD_A         = 32'd5;
  localparam logic [`CPU_XLEN-1:0] WORD_B         = 32'd9;
  localparam logic [6:0]           OPC_LOAD       = 7'b0000011;
  localparam logic [6:0]           OPC_IMM        = 7'b0010011;
  localparam logic                 ROW_POKE       = 1'b0;
  localparam logic                 ROW_WAIT_DONE  = 1'b1;

  typedef struct packed {
    logic                 kind;
    logic [`CPU_XLEN-1:0] addr;
    logic [`CPU_XLEN-1:0] value;  // Data word, or drain cycles after the last store
  } stim_row_t;

  logic                 clk;
  logic                 rst_n;
  logic [`CPU_XLEN-1:0] instr_addr;
  logic [`CPU_XLEN-1:0] instr_data;
  logic [`CPU_XLEN-1:0] data_addr;
  logic [`CPU_XLEN-1:0] data_wdata;
  logic                 data_we;
  logic [`CPU_XLEN-1:0] data_rdata;
  logic [`CPU_XLEN-1:0] imem [32] = '{default: `CPU_NOP};
  logic [`CPU_XLEN-1:0] dmem [64];
  logic                 done;
  logic                 final_check = 1'b0;
  logic                 timed_out;
  int                   store_errors;
  int                   reset_errors = 0;
  int                   cycles = 0;

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [6:0] opc,
                                         input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input int rs1, input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic stim_row_t stim_row(input int n);
    case (n)
      0:       return '{ROW_POKE, 32'd0, WORD_A};
      1:       return '{ROW_POKE, 32'd4, WORD_B};
      default: return '{ROW_WAIT_DONE, 32'd0, 32'd8};
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Program table
  initial begin
    imem[0]  = i_type(3'b010, OPC_LOAD, 1, 0, 0);        // x1 = 5
    imem[1]  = i_type(3'b010, OPC_LOAD, 2, 0, 4);        // x2 = 9
    imem[2]  = r_type(7'h00, 3'b000, 3, 1, 2);           // Load-use on x2
    imem[3]  = s_type(3, 0, 8);
    imem[4]  = r_type(7'h20, 3'b000, 4, 2, 1);           // SUB
    imem[5]  = s_type(4, 0, 12);
    imem[6]  = r_type(7'h00, 3'b111, 5, 1, 2);           // AND
    imem[7]  = s_type(5, 0, 16);
    imem[8]  = r_type(7'h00, 3'b110, 6, 1, 2);           // OR
    imem[9]  = s_type(6, 0, 20);
    imem[10] = i_type(3'b000, OPC_IMM, 7, 1, 100);
    imem[11] = s_type(7, 0, 24);
    imem[12] = i_type(3'b000, OPC_IMM, 8, 0, 3);
    imem[13] = r_type(7'h00, 3'b000, 9, 8, 8);           // Distance one
    imem[14] = r_type(7'h00, 3'b000, 10, 9, 8);          // Distances one and two
    imem[15] = s_type(10, 0, 28);
    imem[16] = i_type(3'b010, OPC_LOAD, 11, 0, 4);
    imem[17] = i_type(3'b000, OPC_IMM, 12, 11, 7);
    imem[18] = s_type(12, 0, 32);
    imem[19] = b_type(1, 1, 12);                         // Taken to word 22
    imem[20] = s_type(1, 0, 36);
    imem[21] = s_type(2, 0, 40);
    imem[22] = s_type(3, 0, 44);
    imem[23] = b_type(1, 2, 8);                          // Not taken
    imem[24] = s_type(4, 0, 48);
    imem[25] = i_type(3'b000, OPC_IMM, 0, 0, 55);        // Write to x0
    imem[26] = s_type(0, 0, 52);
  end

  // Every word starts out tagged with its own address
  initial begin
    for (logic [6:0] a = 7'd0; a < 7'd64; a++) begin
      dmem[a[5:0]] = 32'h5a00_0000 | {23'd0, a, 2'b00};
    end
  end

  assign instr_data = ((instr_addr >> 2) < PROG_LEN) ? imem[instr_addr[6:2]] : `CPU_NOP;
  assign data_rdata = dmem[data_addr[7:2]];

  always @(posedge clk) begin
    if (rst_n && data_we) begin
      dmem[data_addr[7:2]] <= data_wdata;
    end
  end

  always @(posedge clk) cycles <= cycles + 1;
  assign timed_out = (cycles >= TIMEOUT_CYCLES);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // DUT and testbench parts
  tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(8)) clock_gen (.clk(clk), .rst_n(rst_n));

  pipelined_cpu u_dut (
    .clk(clk), .rst_n(rst_n), .instr_addr(instr_addr), .instr_data(instr_data),
    .data_addr(data_addr), .data_wdata(data_wdata), .data_we(data_we),
    .data_rdata(data_rdata)
  );

  tb_checker #(.WORD_A(WORD_A), .WORD_B(WORD_B)) store_check (
    .clk(clk), .rst_n(rst_n), .data_we(data_we), .data_addr(data_addr),
    .data_wdata(data_wdata), .final_check(final_check), .done(done), .errors(store_errors)
  );

  bind pipelined_cpu cpu_assertions assertions (
    .clk(clk), .rst_n(rst_n), .data_we(data_we), .stall_f(stall_f), .stall_d(stall_d),
    .flush_d(flush_d), .flush_e(flush_e), .branch_taken(branch_taken)
  );

  initial begin : run_program
    stim_row_t row;
    @(posedge rst_n);
    if (instr_addr !== `CPU_RESET_PC) begin
      $display("Mismatch at time %0t: first fetch at 0x%08h, expected 0x%08h",
               $time, instr_addr, `CPU_RESET_PC);
      reset_errors++;
    end
    if (data_we !== 1'b0) begin
      $display("Store strobe is high when reset is released");
      reset_errors++;
    end
    @(posedge clk);
    #1;
    for (int n = 0; n < N_ROWS; n++) begin
      row = stim_row(n);
      if (row.kind == ROW_POKE) begin
        dmem[row.addr[7:2]] = row.value;
      end else begin
        while (!done && !timed_out) @(posedge clk);
        repeat (row.value) @(posedge clk);
        #1;
      end
    end
    if (timed_out) begin
      $display("Timeout: the program did not finish its stores within %0d cycles",
               TIMEOUT_CYCLES);
    end
    final_check = 1'b1;
    @(posedge clk);
    #1;
    $display("Errors: %0d store, %0d reset, %0d timeout",
             store_errors, reset_errors, int'(timed_out));
    if (store_errors == 0 && reset_errors == 0 && !timed_out) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/pipe_reg.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/pipelined_cpu.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/cpu_assertions.sv
testbench/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the simulation with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  exit 0
fi
exit 1
